// File: design/plus_glue_config.svh
`ifndef PLUS_GLUE_CONFIG_SVH
`define PLUS_GLUE_CONFIG_SVH

// --------------------
// floppy image sizes
// --------------------

// last word address of an 819200 byte image
`define PT_DS_LAST_WORD 23'd409599

// last word address of a 409600 byte image
`define PT_SS_LAST_WORD 23'd204799

// --------------------
// memory map
// --------------------

// drive images sit right after the os rom
`define PT_DSK1_OFFSET 21'h080000
`define PT_DSK2_OFFSET 21'h100000

// --------------------
// timing
// --------------------

// reset hold in clk8 enables
// 65535 gives the ~8ms used on hardware
`define PT_RESET_HOLD 16'd64

// clk32 cycles per bus phase
`define PT_PHASE_CLKS 4

`endif

// File: design/plus_pkg.sv
package plus_pkg;

	// --------------------
	// download port
	// --------------------

	// byte address as delivered by the io controller
	typedef logic [23:0] dl_addr_t;

	// 0 os rom, 1 first drive, 2 second drive
	typedef logic [4:0] dl_index_t;

	typedef logic [7:0] byte_t;

	// --------------------
	// memory side
	// --------------------

	// 68000 word address into ram/rom
	typedef logic [20:0] word_addr_t;

	// full sdram word address with region prefix
	typedef logic [24:0] sdram_addr_t;

	typedef logic [15:0] mem_data_t;

	// 0 64K, 1 128K, 2 256K, 3 512K
	typedef logic [1:0] rom_size_t;

	// --------------------
	// bus timing
	// --------------------

	// one full rotation is one 68000 bus cycle at 8MHz x4
	typedef enum logic [1:0] {
		PH_VIDEO = 2'b00,
		PH_CPU0  = 2'b01,
		PH_IO    = 2'b10,
		PH_CPU1  = 2'b11
	} bus_phase_t;

endpackage

// File: design/plus_ifs.sv
`timescale 1ns/1ps

// download port as seen inside the design
interface dl_bus_if;
	import plus_pkg::*;

	logic      active;
	dl_index_t index;
	dl_addr_t  addr;
	byte_t     data;
	logic      wr;

	// places the bytes in memory
	modport writer (
		input index,
		input addr,
		input data,
		input wr
	);

	// watches the end of each file
	modport tracker (
		input active,
		input index,
		input addr,
		input wr
	);
endinterface

// one sdram request
interface mem_req_if;
	import plus_pkg::*;

	sdram_addr_t addr;
	mem_data_t   din;
	logic [1:0]  ds;
	logic        we;
	logic        oe;

	modport source (
		output addr,
		output din,
		output ds,
		output we,
		output oe
	);

	modport sink (
		input addr,
		input din,
		input ds,
		input we,
		input oe
	);
endinterface

// File: design/bus_phase_gen.sv
`timescale 1ns/1ps
`include "plus_glue_config.svh"

module bus_phase_gen (
	input  logic                 clk32,
	input  logic                 rst_i,
	output logic                 clk8_en_o,
	output plus_pkg::bus_phase_t phase_o
);
	import plus_pkg::*;

	localparam int CNT_W = $clog2(`PT_PHASE_CLKS);

	logic [CNT_W-1:0] cnt_q;

	// last clk32 cycle of each phase
	assign clk8_en_o = (cnt_q == CNT_W'(`PT_PHASE_CLKS - 1));

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			cnt_q   <= '0;
			phase_o <= PH_VIDEO;
		end else begin
			cnt_q <= clk8_en_o ? '0 : cnt_q + 1'b1;
			if (clk8_en_o) begin
				// video, cpu, io, cpu
				case (phase_o)
					PH_VIDEO: phase_o <= PH_CPU0;
					PH_CPU0:  phase_o <= PH_IO;
					PH_IO:    phase_o <= PH_CPU1;
					default:  phase_o <= PH_VIDEO;
				endcase
			end
		end
	end

endmodule

// File: design/download_writer.sv
`timescale 1ns/1ps
`include "plus_glue_config.svh"

module download_writer (
	input  logic                 clk32,
	input  logic                 rst_i,
	dl_bus_if.writer             dl,
	input  plus_pkg::bus_phase_t phase_i,
	input  logic                 clk8_en_i,
	mem_req_if.source            req,
	output logic                 dl_ready_o
);
	import plus_pkg::*;

	logic       pend_q;
	logic       slot_q;
	word_addr_t word_offset;
	word_addr_t word_addr;

	// rom at 0, disk images behind it
	always_comb begin
		case (dl.index)
			5'd0:    word_offset = '0;
			5'd1:    word_offset = `PT_DSK1_OFFSET;
			default: word_offset = `PT_DSK2_OFFSET;
		endcase
	end

	// byte address counts bytes, memory counts words
	assign word_addr = dl.addr[21:1] + word_offset;

	// --------------------
	// request to sdram
	// --------------------
	assign req.addr = {4'b0001, word_addr};
	assign req.din  = {dl.data, dl.data};
	assign req.ds   = {~dl.addr[0], dl.addr[0]};
	assign req.we   = slot_q;
	assign req.oe   = 1'b0;

	assign dl_ready_o = ~pend_q;

	// a write only owns an io phase it was pending for from the start
	always_ff @(posedge clk32) begin
		if (rst_i) begin
			pend_q <= 1'b0;
			slot_q <= 1'b0;
		end else begin
			if (dl.wr && !pend_q) begin
				pend_q <= 1'b1;
			end
			if (clk8_en_i && phase_i == PH_CPU0) begin
				slot_q <= pend_q | dl.wr;
			end else if (clk8_en_i && phase_i == PH_IO) begin
				slot_q <= 1'b0;
				// done at the end of the slot
				if (slot_q) begin
					pend_q <= 1'b0;
				end
			end
		end
	end

endmodule

// File: design/image_tracker.sv
`timescale 1ns/1ps
`include "plus_glue_config.svh"

module image_tracker (
	input  logic                clk32,
	input  logic                rst_i,
	dl_bus_if.tracker           dl,
	input  logic [1:0]          eject_i,
	output logic [1:0]          disk_inserted_o,
	output logic [1:0]          disk_double_o,
	output plus_pkg::rom_size_t rom_size_o
);
	import plus_pkg::*;

	logic        active_d;
	logic        fall_q;
	logic [22:0] last_word_q;
	dl_index_t   idx_q;
	logic [1:0]  ds_q;
	logic [1:0]  ss_q;

	// --------------------
	// end of download
	// --------------------
	always_ff @(posedge clk32) begin
		if (rst_i) begin
			active_d <= 1'b0;
			fall_q   <= 1'b0;
		end else begin
			active_d <= dl.active;
			fall_q   <= active_d & ~dl.active;
		end
	end

	// final word address and file of the running download
	always_ff @(posedge clk32) begin
		if (dl.active) begin
			last_word_q <= dl.addr[23:1];
			idx_q       <= dl.index;
		end
	end

	// --------------------
	// drive flags
	// --------------------
	for (genvar d = 0; d < 2; d++) begin : g_drive
		always_ff @(posedge clk32) begin
			if (rst_i) begin
				ds_q[d] <= 1'b0;
				ss_q[d] <= 1'b0;
			end else if (eject_i[d]) begin
				ds_q[d] <= 1'b0;
				ss_q[d] <= 1'b0;
			end else if (fall_q && idx_q == dl_index_t'(d + 1)) begin
				// anything else is an unknown image
				ds_q[d] <= (last_word_q == `PT_DS_LAST_WORD);
				ss_q[d] <= (last_word_q == `PT_SS_LAST_WORD);
			end
		end
	end

	assign disk_inserted_o = ds_q | ss_q;
	assign disk_double_o   = ds_q;

	// rom size follows the highest address bit written
	always_ff @(posedge clk32) begin
		if (rst_i) begin
			rom_size_o <= '0;
		end else if (dl.wr && dl.index == '0) begin
			rom_size_o <= {|dl.addr[18:17], dl.addr[18] | (dl.addr[16] & ~dl.addr[17])};
		end
	end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                  clk32,
	input  logic                  rst_i,
	input  plus_pkg::bus_phase_t  phase_i,
	input  logic                  dl_active_i,
	mem_req_if.sink               dl_req,
	mem_req_if.sink               cpu_req,
	input  logic                  disk_read_i,
	input  logic                  cpu_byte_sel_i,
	output plus_pkg::sdram_addr_t sdram_addr_o,
	output plus_pkg::mem_data_t   sdram_din_o,
	output logic [1:0]            sdram_ds_o,
	output logic                  sdram_we_o,
	output logic                  sdram_oe_o,
	input  plus_pkg::mem_data_t   sdram_data_i,
	output plus_pkg::mem_data_t   cpu_data_o
);
	import plus_pkg::*;

	logic      dl_slot;
	mem_data_t disk_data;

	// download owns the io phase while a file is coming in
	assign dl_slot = dl_active_i && (phase_i == PH_IO);

	// --------------------
	// request mux
	// --------------------
	always_ff @(posedge clk32) begin
		if (dl_slot) begin
			sdram_addr_o <= dl_req.addr;
			sdram_din_o  <= dl_req.din;
			sdram_ds_o   <= dl_req.ds;
		end else begin
			sdram_addr_o <= cpu_req.addr;
			sdram_din_o  <= cpu_req.din;
			sdram_ds_o   <= cpu_req.ds;
		end
	end

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			sdram_we_o <= 1'b0;
			sdram_oe_o <= 1'b0;
		end else begin
			sdram_we_o <= dl_slot ? dl_req.we : cpu_req.we;
			sdram_oe_o <= dl_slot ? dl_req.oe : cpu_req.oe;
		end
	end

	// --------------------
	// read data
	// --------------------

	// disk images are read byte wide
	assign disk_data = cpu_byte_sel_i ? {sdram_data_i[7:0], sdram_data_i[7:0]}
	                                  : {sdram_data_i[15:8], sdram_data_i[15:8]};

	// ffff keeps the screen black during a download
	always_comb begin
		if (dl_slot) begin
			cpu_data_o = 16'hffff;
		end else if (disk_read_i) begin
			cpu_data_o = disk_data;
		end else begin
			cpu_data_o = sdram_data_i;
		end
	end

endmodule

// File: design/reset_stretch.sv
`timescale 1ns/1ps
`include "plus_glue_config.svh"

module reset_stretch (
	input  logic                clk32,
	input  logic                rst_i,
	input  logic                clk8_en_i,
	input  logic                dl_active_i,
	input  plus_pkg::dl_index_t dl_index_i,
	input  logic                user_reset_i,
	input  logic                cpu_reset_req_i,
	input  logic                mem_4mb_i,
	output logic                cpu_reset_n_o
);
	import plus_pkg::*;

	logic [15:0] hold_cnt_q;
	logic        mem_last_q;
	logic        rom_dl;
	logic        src;

	assign rom_dl = dl_active_i && (dl_index_i == dl_index_t'(0));

	// memory size change needs a cold start
	assign src = user_reset_i | rom_dl | cpu_reset_req_i | (mem_4mb_i ^ mem_last_q);

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			hold_cnt_q <= `PT_RESET_HOLD;
			mem_last_q <= mem_4mb_i;
		end else if (clk8_en_i) begin
			mem_last_q <= mem_4mb_i;
			if (src) begin
				hold_cnt_q <= `PT_RESET_HOLD;
			end else if (hold_cnt_q != '0) begin
				hold_cnt_q <= hold_cnt_q - 1'b1;
			end
		end
	end

	assign cpu_reset_n_o = (hold_cnt_q == '0) && !src;

endmodule

// File: design/plus_glue.sv
`timescale 1ns/1ps

module plus_glue (
	input  logic                  clk32,
	input  logic                  rst_i,
	// download port
	input  logic                  dl_active_i,
	input  plus_pkg::dl_index_t   dl_index_i,
	input  plus_pkg::dl_addr_t    dl_addr_i,
	input  plus_pkg::byte_t       dl_data_i,
	input  logic                  dl_wr_i,
	output logic                  dl_ready_o,
	// floppy status
	input  logic [1:0]            eject_i,
	output logic [1:0]            disk_inserted_o,
	output logic [1:0]            disk_double_o,
	output plus_pkg::rom_size_t   rom_size_o,
	// cpu memory request
	input  plus_pkg::word_addr_t  cpu_addr_i,
	input  logic                  cpu_rom_sel_i,
	input  plus_pkg::mem_data_t   cpu_din_i,
	input  logic [1:0]            cpu_ds_i,
	input  logic                  cpu_we_i,
	input  logic                  cpu_oe_i,
	input  logic                  cpu_byte_sel_i,
	input  logic                  disk_read_i,
	output plus_pkg::mem_data_t   cpu_data_o,
	// sdram port
	output plus_pkg::sdram_addr_t sdram_addr_o,
	output plus_pkg::mem_data_t   sdram_din_o,
	output logic [1:0]            sdram_ds_o,
	output logic                  sdram_we_o,
	output logic                  sdram_oe_o,
	input  plus_pkg::mem_data_t   sdram_data_i,
	// reset sources
	input  logic                  user_reset_i,
	input  logic                  cpu_reset_req_i,
	input  logic                  mem_4mb_i,
	output logic                  cpu_reset_n_o
);
	import plus_pkg::*;

	logic       clk8_en;
	bus_phase_t phase;

	dl_bus_if  dl_bus ();
	mem_req_if dl_req ();
	mem_req_if cpu_req ();

	// --------------------
	// download port
	// --------------------
	assign dl_bus.active = dl_active_i;
	assign dl_bus.index  = dl_index_i;
	assign dl_bus.addr   = dl_addr_i;
	assign dl_bus.data   = dl_data_i;
	assign dl_bus.wr     = dl_wr_i;

	// rom select picks the rom region in sdram
	assign cpu_req.addr = {3'b000, cpu_rom_sel_i, cpu_addr_i};
	assign cpu_req.din  = cpu_din_i;
	assign cpu_req.ds   = cpu_ds_i;
	assign cpu_req.we   = cpu_we_i;
	assign cpu_req.oe   = cpu_oe_i;

	bus_phase_gen u_phase (
		.clk32     (clk32),
		.rst_i     (rst_i),
		.clk8_en_o (clk8_en),
		.phase_o   (phase)
	);

	download_writer u_writer (
		.clk32      (clk32),
		.rst_i      (rst_i),
		.dl         (dl_bus),
		.phase_i    (phase),
		.clk8_en_i  (clk8_en),
		.req        (dl_req),
		.dl_ready_o (dl_ready_o)
	);

	image_tracker u_tracker (
		.clk32           (clk32),
		.rst_i           (rst_i),
		.dl              (dl_bus),
		.eject_i         (eject_i),
		.disk_inserted_o (disk_inserted_o),
		.disk_double_o   (disk_double_o),
		.rom_size_o      (rom_size_o)
	);

	mem_arbiter u_arbiter (
		.clk32          (clk32),
		.rst_i          (rst_i),
		.phase_i        (phase),
		.dl_active_i    (dl_active_i),
		.dl_req         (dl_req),
		.cpu_req        (cpu_req),
		.disk_read_i    (disk_read_i),
		.cpu_byte_sel_i (cpu_byte_sel_i),
		.sdram_addr_o   (sdram_addr_o),
		.sdram_din_o    (sdram_din_o),
		.sdram_ds_o     (sdram_ds_o),
		.sdram_we_o     (sdram_we_o),
		.sdram_oe_o     (sdram_oe_o),
		.sdram_data_i   (sdram_data_i),
		.cpu_data_o     (cpu_data_o)
	);

	reset_stretch u_reset (
		.clk32           (clk32),
		.rst_i           (rst_i),
		.clk8_en_i       (clk8_en),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.user_reset_i    (user_reset_i),
		.cpu_reset_req_i (cpu_reset_req_i),
		.mem_4mb_i       (mem_4mb_i),
		.cpu_reset_n_o   (cpu_reset_n_o)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

// free running clk32 for the bench
module tb_clock #(
	parameter real PERIOD_NS = 100.0
) (
	output logic clk32_o
);

	initial begin
		clk32_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk32_o = ~clk32_o;
	end

endmodule

// File: bench/tb_plus_glue.sv
`timescale 1ns/1ps
`include "plus_glue_config.svh"

module tb_plus_glue;
	import plus_pkg::*;

	localparam int RELEASE_LIMIT = `PT_RESET_HOLD * 4 + 40;
	localparam int WRITE_LIMIT   = 20;

	logic        clk32;
	logic        rst;
	logic        dl_active;
	dl_index_t   dl_index;
	dl_addr_t    dl_addr;
	byte_t       dl_data;
	logic        dl_wr;
	logic        dl_ready;
	logic [1:0]  eject;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_double;
	rom_size_t   rom_size;
	word_addr_t  cpu_addr;
	logic        cpu_rom_sel;
	mem_data_t   cpu_din;
	logic [1:0]  cpu_ds;
	logic        cpu_we;
	logic        cpu_oe;
	logic        cpu_byte_sel;
	logic        disk_read;
	mem_data_t   cpu_data;
	sdram_addr_t sdram_addr;
	mem_data_t   sdram_din;
	logic [1:0]  sdram_ds;
	logic        sdram_we;
	logic        sdram_oe;
	mem_data_t   sdram_data;
	logic        user_reset;
	logic        cpu_reset_req;
	logic        mem_4mb;
	logic        cpu_reset_n;

	integer seed;
	logic   started;

	// --------------------
	// reference model state
	// --------------------
	logic [1:0]  m_cnt;
	logic [1:0]  m_phase;
	logic        m_pend;
	logic        m_slot;
	sdram_addr_t m_sd_addr;
	mem_data_t   m_sd_din;
	logic [1:0]  m_sd_ds;
	logic        m_sd_we;
	logic        m_sd_oe;
	logic        m_act_d;
	logic        m_fall;
	logic [22:0] m_last;
	dl_index_t   m_idx;
	logic [1:0]  m_ds;
	logic [1:0]  m_ss;
	rom_size_t   m_rom;
	logic [15:0] m_hold;
	logic        m_mem_last;

	tb_clock u_clock (
		.clk32_o (clk32)
	);

	plus_glue dut (
		.clk32 (clk32), .rst_i (rst),
		.dl_active_i (dl_active), .dl_index_i (dl_index), .dl_addr_i (dl_addr),
		.dl_data_i (dl_data), .dl_wr_i (dl_wr), .dl_ready_o (dl_ready),
		.eject_i (eject), .disk_inserted_o (disk_inserted),
		.disk_double_o (disk_double), .rom_size_o (rom_size),
		.cpu_addr_i (cpu_addr), .cpu_rom_sel_i (cpu_rom_sel), .cpu_din_i (cpu_din),
		.cpu_ds_i (cpu_ds), .cpu_we_i (cpu_we), .cpu_oe_i (cpu_oe),
		.cpu_byte_sel_i (cpu_byte_sel), .disk_read_i (disk_read), .cpu_data_o (cpu_data),
		.sdram_addr_o (sdram_addr), .sdram_din_o (sdram_din), .sdram_ds_o (sdram_ds),
		.sdram_we_o (sdram_we), .sdram_oe_o (sdram_oe), .sdram_data_i (sdram_data),
		.user_reset_i (user_reset), .cpu_reset_req_i (cpu_reset_req),
		.mem_4mb_i (mem_4mb), .cpu_reset_n_o (cpu_reset_n)
	);

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
	                           input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// rom at 0, drive images at their fixed offsets
	function automatic word_addr_t mapped_word(dl_index_t idx, dl_addr_t a);
		word_addr_t offset;
		case (idx)
			5'd0:    offset = '0;
			5'd1:    offset = `PT_DSK1_OFFSET;
			default: offset = `PT_DSK2_OFFSET;
		endcase
		return a[21:1] + offset;
	endfunction

	function automatic rom_size_t rom_rule(dl_addr_t a);
		if (a[18])
			return 2'd3;
		if (a[17])
			return 2'd2;
		if (a[16])
			return 2'd1;
		return 2'd0;
	endfunction

	function automatic logic source_present();
		return user_reset | cpu_reset_req | (dl_active && dl_index == 5'd0)
			| (mem_4mb != m_mem_last);
	endfunction

	function automatic mem_data_t expected_read();
		if (dl_active && m_phase == PH_IO)
			return 16'hffff;
		if (disk_read)
			return cpu_byte_sel ? {sdram_data[7:0], sdram_data[7:0]}
			                    : {sdram_data[15:8], sdram_data[15:8]};
		return sdram_data;
	endfunction

	// advance the model by one clk32 edge from the old state
	task automatic update_model();
		logic en;
		logic slot_now;
		logic old_pend;
		logic old_slot;
		logic src;
		en       = (m_cnt == 2'd3);
		slot_now = dl_active && (m_phase == PH_IO);
		old_pend = m_pend;
		old_slot = m_slot;
		src      = source_present();
		if (slot_now) begin
			m_sd_addr = {4'b0001, mapped_word(dl_index, dl_addr)};
			m_sd_din  = {dl_data, dl_data};
			m_sd_ds   = {~dl_addr[0], dl_addr[0]};
			m_sd_we   = old_slot;
			m_sd_oe   = 1'b0;
		end else begin
			m_sd_addr = {3'b000, cpu_rom_sel, cpu_addr};
			m_sd_din  = cpu_din;
			m_sd_ds   = cpu_ds;
			m_sd_we   = cpu_we;
			m_sd_oe   = cpu_oe;
		end
		if (rst) begin
			m_sd_we = 1'b0;
			m_sd_oe = 1'b0;
			m_pend  = 1'b0;
			m_slot  = 1'b0;
		end else begin
			if (dl_wr && !old_pend)
				m_pend = 1'b1;
			// a write owns the io phase that starts after it
			if (en && m_phase == PH_CPU0) begin
				m_slot = old_pend | dl_wr;
			end else if (en && m_phase == PH_IO) begin
				m_slot = 1'b0;
				if (old_slot)
					m_pend = 1'b0;
			end
		end
		for (int d = 0; d < 2; d++) begin
			if (rst || eject[d]) begin
				m_ds[d] = 1'b0;
				m_ss[d] = 1'b0;
			end else if (m_fall && m_idx == 5'(d + 1)) begin
				m_ds[d] = (m_last == `PT_DS_LAST_WORD);
				m_ss[d] = (m_last == `PT_SS_LAST_WORD);
			end
		end
		if (rst)
			m_rom = '0;
		else if (dl_wr && dl_index == 5'd0)
			m_rom = rom_rule(dl_addr);
		m_fall  = rst ? 1'b0 : (m_act_d & ~dl_active);
		m_act_d = rst ? 1'b0 : dl_active;
		if (dl_active) begin
			m_last = dl_addr[23:1];
			m_idx  = dl_index;
		end
		if (rst) begin
			m_hold     = `PT_RESET_HOLD;
			m_mem_last = mem_4mb;
		end else if (en) begin
			if (src)
				m_hold = `PT_RESET_HOLD;
			else if (m_hold != 16'd0)
				m_hold = m_hold - 16'd1;
			m_mem_last = mem_4mb;
		end
		if (rst) begin
			m_cnt   = 2'd0;
			m_phase = PH_VIDEO;
		end else if (en) begin
			m_cnt   = 2'd0;
			m_phase = m_phase + 2'd1;
		end else begin
			m_cnt = m_cnt + 2'd1;
		end
	endtask

	task automatic compare_outputs();
		logic exp_rst_n;
		exp_rst_n = (m_hold == 16'd0) && !source_present();
		check_value(dl_ready, !m_pend, "dl_ready_o");
		check_value(disk_inserted, m_ds | m_ss, "disk_inserted_o");
		check_value(disk_double, m_ds, "disk_double_o");
		check_value(rom_size, m_rom, "rom_size_o");
		check_value(sdram_addr, m_sd_addr, "sdram_addr_o");
		check_value(sdram_din, m_sd_din, "sdram_din_o");
		check_value(sdram_ds, m_sd_ds, "sdram_ds_o");
		check_value(sdram_we, m_sd_we, "sdram_we_o");
		check_value(sdram_oe, m_sd_oe, "sdram_oe_o");
		check_value(cpu_data, expected_read(), "cpu_data_o");
		check_value(cpu_reset_n, exp_rst_n, "cpu_reset_n_o");
	endtask

	// random cpu side, check, then move to 10 ns after the next edge
	task automatic next_cycle();
		cpu_addr     = word_addr_t'($random(seed));
		cpu_rom_sel  = 1'($random(seed));
		cpu_din      = mem_data_t'($random(seed));
		cpu_ds       = 2'($random(seed));
		cpu_we       = 1'($random(seed));
		cpu_oe       = 1'($random(seed));
		cpu_byte_sel = 1'($random(seed));
		disk_read    = 1'($random(seed));
		sdram_data   = mem_data_t'($random(seed));
		#1;
		if (started)
			compare_outputs();
		@(posedge clk32);
		update_model();
		started = 1'b1;
		#10;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (dl_ready !== 1'b1) begin
			if (n >= WRITE_LIMIT)
				report_timeout("dl_ready_o stayed low after a download write");
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (cpu_reset_n !== 1'b1) begin
			if (n >= RELEASE_LIMIT)
				report_timeout("cpu_reset_n_o was never released");
			next_cycle();
			n++;
		end
	endtask

	task automatic write_byte(input dl_addr_t a);
		wait_ready();
		dl_addr = a;
		dl_data = byte_t'($random(seed));
		dl_wr   = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		wait_ready();
	endtask

	// a few random bytes, then the final address of the file
	task automatic download_file(input dl_index_t idx, input dl_addr_t last, input int n);
		dl_active = 1'b1;
		dl_index  = idx;
		next_cycle();
		for (int i = 0; i < n; i++)
			write_byte(dl_addr_t'($random(seed)) & last);
		write_byte(last);
		next_cycle();
		dl_active = 1'b0;
		repeat (4) next_cycle();
	endtask

	task automatic eject_drive(input logic [1:0] which);
		eject = which;
		next_cycle();
		eject = 2'b00;
		repeat (2) next_cycle();
	endtask

	task automatic pulse_source(input int kind);
		case (kind)
			0:       user_reset = 1'b1;
			1:       cpu_reset_req = 1'b1;
			default: mem_4mb = ~mem_4mb;
		endcase
		repeat (6) next_cycle();
		user_reset    = 1'b0;
		cpu_reset_req = 1'b0;
		wait_reset_release();
	endtask

	initial begin
		seed          = 32'h0ec174c0;
		started       = 1'b0;
		rst           = 1'b1;
		dl_active     = 1'b0;
		dl_index      = '0;
		dl_addr       = '0;
		dl_data       = '0;
		dl_wr         = 1'b0;
		eject         = 2'b00;
		cpu_addr      = '0;
		cpu_rom_sel   = 1'b0;
		cpu_din       = '0;
		cpu_ds        = 2'b00;
		cpu_we        = 1'b0;
		cpu_oe        = 1'b0;
		cpu_byte_sel  = 1'b0;
		disk_read     = 1'b0;
		sdram_data    = '0;
		user_reset    = 1'b0;
		cpu_reset_req = 1'b0;
		mem_4mb       = 1'b0;
		repeat (4) next_cycle();
		rst = 1'b0;
		wait_reset_release();

		// cpu traffic outside download slots
		repeat (200) next_cycle();

		// --------------------
		// rom downloads
		// --------------------
		for (int i = 0; i < 4; i++) begin
			download_file(5'd0, dl_addr_t'($random(seed)) & 24'h07ffff, 3);
			wait_reset_release();
		end

		// floppy images of known and unknown size
		download_file(5'd1, {`PT_DS_LAST_WORD, 1'b1}, 3);
		download_file(5'd2, {`PT_SS_LAST_WORD, 1'b1}, 3);
		eject_drive(2'b01);
		download_file(5'd1, {`PT_SS_LAST_WORD, 1'b0}, 3);
		download_file(5'd2, dl_addr_t'($random(seed)) & 24'h0fffff, 3);
		eject_drive(2'b10);
		download_file(5'd2, {`PT_DS_LAST_WORD, 1'b0}, 3);
		eject_drive(2'b11);

		// --------------------
		// reset sources
		// --------------------
		for (int k = 0; k < 4; k++)
			pulse_source(k);
		repeat (40) next_cycle();

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: plus_glue.f
+incdir+design
design/plus_pkg.sv
design/plus_ifs.sv
design/bus_phase_gen.sv
design/download_writer.sv
design/image_tracker.sv
design/mem_arbiter.sv
design/reset_stretch.sv
design/plus_glue.sv
bench/tb_clock.sv
bench/tb_plus_glue.sv

// File: Bender.yml
package:
  name: plus_glue

sources:
  - include_dirs:
      - design
    files:
      - design/plus_pkg.sv
      - design/plus_ifs.sv
      - design/bus_phase_gen.sv
      - design/download_writer.sv
      - design/image_tracker.sv
      - design/mem_arbiter.sv
      - design/reset_stretch.sv
      - design/plus_glue.sv
      - target: test
        files:
          - bench/tb_clock.sv
          - bench/tb_plus_glue.sv
